// File: files.f
+incdir+hdl
hdl/elev_floor_pkg.sv
hdl/elev_car_pkg.sv
hdl/call_latch.sv
hdl/call_stack.sv
hdl/car_dispatcher.sv
hdl/floor_logic_top.sv
bench/floor_logic_assert.sv
bench/floor_logic_tb.sv

// File: bench/floor_logic_tb.sv
`timescale 1ns/1ps
`include "elev_params.svh"

module floor_logic_tb;

    import elev_floor_pkg::*;
    import elev_car_pkg::*;

    // Tests take well under a hundred cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [15:0] LFSR_SEED = 16'd19314;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic        clock;
    logic        reset_n;
    floor_vec_t  car_buttons;
    floor_vec_t  hall_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    car_status_t status;
    dispatch_t   dispatch;
    floor_vec_t  car_lights;
    floor_vec_t  hall_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    logic [15:0] lfsr_state;
    floor_t      cur_floor;
    // Floor that the pending requests should make the target
    floor_t      expected_target;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          cycle_count = 0;

    floor_logic_top uut (
        .clock, .reset_n, .car_buttons, .hall_buttons,
        .door_open_button, .door_close_button, .emergency_button, .power_switch,
        .status, .dispatch, .car_lights, .hall_lights,
        .door_open_allowed, .door_close_allowed
    );

    bind floor_logic_top floor_logic_assert assertions (
        .clock, .reset_n, .emergency_button, .power_switch, .status, .dispatch,
        .car_lights, .hall_lights, .door_open_allowed, .door_close_allowed
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic floor_vec_t floor_mask(input floor_t fl);
        return floor_vec_t'(1) << fl;
    endfunction

    // Random floor below limit and outside the skip set
    function automatic floor_t pick_floor(input int limit, input floor_vec_t skip);
        floor_t v;
        logic   found;
        v = '0;
        found = 1'b0;
        for (int tries = 0; tries < 256 && !found; tries++) begin
            for (int b = 0; b < `ELEV_FLOOR_W; b++) begin
                v[b] = lfsr_bit();
            end
            if (v < limit) begin
                found = !skip[v];
            end
        end
        return v;
    endfunction

    function automatic car_status_t make_status(input int code, input floor_t fl);
        car_status_t s;
        s.state = car_state_t'(code[`ELEV_STATE_W-1:0]);
        s.floor = fl;
        return s;
    endfunction

    // A travel state leaving the given floor
    function automatic int travel_code(input floor_t fl);
        return (fl < `ELEV_NUM_FLOORS - 1) ? 11 + fl : 21;
    endfunction

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s finished cleanly", name);
        end else begin
            $display("Test %s finished with %0d mismatches", name,
                     error_count - errors_before);
        end
    endtask

    task automatic step();
        @(posedge clock);
        @(negedge clock);
    endtask

    // Hold one button for a cycle, sample after the accepting edge
    task automatic press(input logic hall, input floor_t fl);
        @(posedge clock);
        if (hall) begin
            hall_buttons <= floor_mask(fl);
        end else begin
            car_buttons <= floor_mask(fl);
        end
        @(posedge clock);
        car_buttons  <= '0;
        hall_buttons <= '0;
        @(negedge clock);
    endtask

    task automatic set_status(input int code, input floor_t fl);
        @(posedge clock);
        status <= make_status(code, fl);
        @(negedge clock);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_values();
        int errors_before;
        errors_before = error_count;
        check("activate after reset", dispatch.activate, 1'b0);
        check("direction after reset", dispatch.direction_up, 1'b1);
        check("car lights after reset", car_lights, '0);
        check("hall lights after reset", hall_lights, '0);
        check("door open after reset", door_open_allowed, 1'b0);
        check("door close after reset", door_close_allowed, 1'b0);
        report_test("reset_values", errors_before);
    endtask

    task automatic stopped_request();
        int     errors_before;
        floor_t f;
        errors_before = error_count;
        f = pick_floor(`ELEV_NUM_FLOORS, floor_mask(cur_floor));
        press(1'b0, f);
        check("car light of request", car_lights[f], 1'b1);
        check("target", dispatch.target, f);
        check("activate", dispatch.activate, 1'b1);
        check("direction up", dispatch.direction_up, f > cur_floor);
        // Car arrives at the requested floor
        set_status(f, f);
        step();
        check("car light after arrival", car_lights[f], 1'b0);
        check("activate after arrival", dispatch.activate, 1'b0);
        check("target after arrival", dispatch.target, f);
        cur_floor = f;
        report_test("stopped_request", errors_before);
    endtask

    task automatic arrival_and_down();
        int     errors_before;
        floor_t g;
        errors_before = error_count;
        g = pick_floor(cur_floor, '0);
        press(1'b1, g);
        check("hall light below", hall_lights[g], 1'b1);
        check("target below", dispatch.target, g);
        check("activate below", dispatch.activate, 1'b1);
        check("direction down", dispatch.direction_up, 1'b0);
        set_status(g, g);
        step();
        check("hall light after arrival", hall_lights[g], 1'b0);
        check("activate after arrival", dispatch.activate, 1'b0);
        check("direction held", dispatch.direction_up, 1'b0);
        cur_floor = g;
        report_test("arrival_and_down", errors_before);
    endtask

    task automatic lifo_travel_priority();
        int     errors_before;
        floor_t a;
        floor_t b;
        floor_t c;
        errors_before = error_count;
        a = pick_floor(`ELEV_NUM_FLOORS, floor_mask(cur_floor));
        b = pick_floor(`ELEV_NUM_FLOORS, floor_mask(cur_floor) | floor_mask(a));
        c = pick_floor(`ELEV_NUM_FLOORS,
                       floor_mask(cur_floor) | floor_mask(a) | floor_mask(b));
        press(1'b0, a);
        press(1'b1, b);
        check("car light A", car_lights[a], 1'b1);
        check("hall light B", hall_lights[b], 1'b1);
        check("last pushed is target", dispatch.target, b);
        check("activate while stopped", dispatch.activate, 1'b1);
        // Press during travel lands in the travel stack
        set_status(travel_code(cur_floor), cur_floor);
        check("activate in travel", dispatch.activate, 1'b0);
        check("target in travel", dispatch.target, cur_floor);
        press(1'b0, c);
        check("car light C", car_lights[c], 1'b1);
        set_status(cur_floor, cur_floor);
        check("travel stack first", dispatch.target, c);
        check("activate after travel", dispatch.activate, 1'b1);
        check("direction after travel", dispatch.direction_up, c > cur_floor);
        expected_target = c;
        report_test("lifo_travel_priority", errors_before);
    endtask

    task automatic own_floor_ignored();
        int errors_before;
        errors_before = error_count;
        press(1'b0, cur_floor);
        check("own car light", car_lights[cur_floor], 1'b0);
        press(1'b1, cur_floor);
        check("own hall light", hall_lights[cur_floor], 1'b0);
        check("target unchanged", dispatch.target, expected_target);
        report_test("own_floor_ignored", errors_before);
    endtask

    task automatic flush_requests();
        int     errors_before;
        floor_t d;
        errors_before = error_count;
        @(posedge clock);
        emergency_button <= 1'b1;
        @(negedge clock);
        check("activate on emergency", dispatch.activate, 1'b0);
        check("target on emergency", dispatch.target, cur_floor);
        step();
        check("car lights after emergency", car_lights, '0);
        check("hall lights after emergency", hall_lights, '0);
        @(posedge clock);
        emergency_button <= 1'b0;
        @(negedge clock);
        check("stacks empty after emergency", dispatch.activate, 1'b0);
        // Same again with the power switch
        d = pick_floor(`ELEV_NUM_FLOORS, floor_mask(cur_floor));
        press(1'b1, d);
        check("activate before power off", dispatch.activate, 1'b1);
        @(posedge clock);
        power_switch <= 1'b0;
        @(negedge clock);
        check("activate on power off", dispatch.activate, 1'b0);
        step();
        check("car lights after power off", car_lights, '0);
        check("hall lights after power off", hall_lights, '0);
        @(posedge clock);
        power_switch <= 1'b1;
        @(negedge clock);
        check("stacks empty after power off", dispatch.activate, 1'b0);
        report_test("flush_requests", errors_before);
    endtask

    task automatic door_gating();
        int errors_before;
        errors_before = error_count;
        @(posedge clock);
        door_open_button <= 1'b1;
        @(negedge clock);
        check("door open at stop", door_open_allowed, 1'b1);
        check("door close idle", door_close_allowed, 1'b0);
        @(posedge clock);
        door_open_button  <= 1'b0;
        door_close_button <= 1'b1;
        @(negedge clock);
        check("door open released", door_open_allowed, 1'b0);
        check("door close at stop", door_close_allowed, 1'b1);
        @(posedge clock);
        door_open_button <= 1'b1;
        status <= make_status(travel_code(cur_floor), cur_floor);
        @(negedge clock);
        check("door open in travel", door_open_allowed, 1'b0);
        check("door close in travel", door_close_allowed, 1'b0);
        @(posedge clock);
        status <= make_status(cur_floor, cur_floor);
        power_switch <= 1'b0;
        @(negedge clock);
        check("door open power off", door_open_allowed, 1'b0);
        check("door close power off", door_close_allowed, 1'b0);
        @(posedge clock);
        power_switch      <= 1'b1;
        door_open_button  <= 1'b0;
        door_close_button <= 1'b0;
        @(negedge clock);
        report_test("door_gating", errors_before);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        clock             = 1'b0;
        reset_n           = 1'b0;
        car_buttons       = '0;
        hall_buttons      = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
        power_switch      = 1'b1;
        status            = make_status(0, '0);
        lfsr_state        = LFSR_SEED;
        cur_floor         = '0;
        expected_target   = '0;

        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);

        reset_values();
        stopped_request();
        arrival_and_down();
        lifo_travel_priority();
        own_floor_ignored();
        flush_requests();
        door_gating();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, error_count, uut.assertions.failures);
        if (error_count == 0 && uut.assertions.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/floor_logic_assert.sv
`timescale 1ns/1ps

module floor_logic_assert (
    input logic                       clock,
    input logic                       reset_n,
    input logic                       emergency_button,
    input logic                       power_switch,
    input elev_car_pkg::car_status_t  status,
    input elev_car_pkg::dispatch_t    dispatch,
    input elev_floor_pkg::floor_vec_t car_lights,
    input elev_floor_pkg::floor_vec_t hall_lights,
    input logic                       door_open_allowed,
    input logic                       door_close_allowed
);

    import elev_car_pkg::*;

    // Number of assertion failures so far
    int failures = 0;

    //////////////////////////////////////////////////
    // Dispatch rules
    //////////////////////////////////////////////////

    // No motion request while the car is shut down
    activate_blocked: assert property (
        @(posedge clock) disable iff (!reset_n)
        (emergency_button || !power_switch) |-> !dispatch.activate
    ) else begin
        failures++;
        $error("activate high during emergency or with power off");
    end

    // A request always names another floor
    activate_moves: assert property (
        @(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> (dispatch.target != status.floor)
    ) else begin
        failures++;
        $error("activate high with target equal to the current floor");
    end

    //////////////////////////////////////////////////
    // Doors and lights
    //////////////////////////////////////////////////

    doors_closed_in_travel: assert property (
        @(posedge clock) disable iff (!reset_n)
        !is_stop_state(status.state) |-> (!door_open_allowed && !door_close_allowed)
    ) else begin
        failures++;
        $error("door output high outside a stop state");
    end

    // Emergency wipes every light at the next edge
    lights_cleared: assert property (
        @(posedge clock) disable iff (!reset_n)
        emergency_button |=> ((car_lights == '0) && (hall_lights == '0))
    ) else begin
        failures++;
        $error("lights still on one cycle after emergency");
    end

endmodule

// File: hdl/floor_logic_top.sv
`timescale 1ns/1ps

module floor_logic_top (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elev_floor_pkg::floor_vec_t car_buttons,
    input  elev_floor_pkg::floor_vec_t hall_buttons,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  logic                       emergency_button,
    input  logic                       power_switch,
    input  elev_car_pkg::car_status_t  status,
    output elev_car_pkg::dispatch_t    dispatch,
    output elev_floor_pkg::floor_vec_t car_lights,
    output elev_floor_pkg::floor_vec_t hall_lights,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elev_floor_pkg::*;

    stack_top_t stopped_top;
    stack_top_t travel_top;
    floor_t     push_floor;
    floor_t     arrive_floor;
    logic       stopped_push;
    logic       travel_push;
    logic       stopped_pop;
    logic       travel_pop;
    logic       stopped_full;
    logic       travel_full;
    logic       flush;
    logic       arrive;

    //////////////////////////////////////////////////
    // Button intake
    //////////////////////////////////////////////////

    call_latch latch (
        .clock, .reset_n, .car_buttons, .hall_buttons, .status,
        .stopped_full, .travel_full, .flush, .arrive, .arrive_floor,
        .car_lights, .hall_lights, .stopped_push, .travel_push, .push_floor
    );

    //////////////////////////////////////////////////
    // Request stacks
    //////////////////////////////////////////////////

    call_stack stopped_stack (
        .clock, .reset_n, .push(stopped_push), .push_floor, .pop(stopped_pop),
        .flush, .top(stopped_top), .full(stopped_full)
    );

    call_stack travel_stack (
        .clock, .reset_n, .push(travel_push), .push_floor, .pop(travel_pop),
        .flush, .top(travel_top), .full(travel_full)
    );

    //////////////////////////////////////////////////
    // Dispatch to the motion FSM
    //////////////////////////////////////////////////

    car_dispatcher dispatcher (
        .clock, .reset_n, .status, .stopped_top, .travel_top,
        .door_open_button, .door_close_button, .emergency_button, .power_switch,
        .dispatch, .stopped_pop, .travel_pop, .flush, .arrive, .arrive_floor,
        .door_open_allowed, .door_close_allowed
    );

endmodule

// File: hdl/car_dispatcher.sv
`timescale 1ns/1ps

module car_dispatcher (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elev_car_pkg::car_status_t  status,
    input  elev_floor_pkg::stack_top_t stopped_top,
    input  elev_floor_pkg::stack_top_t travel_top,
    input  logic                       door_open_button,
    input  logic                       door_close_button,
    input  logic                       emergency_button,
    input  logic                       power_switch,
    output elev_car_pkg::dispatch_t    dispatch,
    output logic                       stopped_pop,
    output logic                       travel_pop,
    output logic                       flush,
    output logic                       arrive,
    output elev_floor_pkg::floor_t     arrive_floor,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);

    import elev_floor_pkg::*;
    import elev_car_pkg::*;

    logic       stopped;
    logic       serve;
    logic       use_travel;
    logic       at_target;
    logic       activate;
    logic       last_up;
    stack_top_t sel_top;
    floor_t     target;

    assign stopped = is_stop_state(status.state);
    assign flush   = !power_switch || emergency_button;
    assign serve   = stopped && !flush;

    //////////////////////////////////////////////////
    // Target selection
    //////////////////////////////////////////////////

    // Requests made during travel go first
    assign use_travel = travel_top.valid;
    assign sel_top    = use_travel ? travel_top : stopped_top;

    assign target   = (serve && sel_top.valid) ? sel_top.floor : status.floor;
    assign activate = serve && (target != status.floor);

    // Car already sits at the selected floor
    assign at_target   = serve && sel_top.valid && (sel_top.floor == status.floor);
    assign travel_pop  = at_target && use_travel;
    assign stopped_pop = at_target && !use_travel;

    assign arrive       = serve;
    assign arrive_floor = status.floor;

    // Direction held between requests, up after reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            last_up <= 1'b1;
        end else if (activate) begin
            last_up <= (target > status.floor);
        end
    end

    always_comb begin
        dispatch.target       = target;
        dispatch.activate     = activate;
        dispatch.direction_up = activate ? (target > status.floor) : last_up;
    end

    // Doors only respond at a landing with power on
    assign door_open_allowed  = stopped && power_switch && door_open_button;
    assign door_close_allowed = stopped && power_switch && door_close_button;

endmodule

// File: hdl/call_stack.sv
`timescale 1ns/1ps
`include "elev_params.svh"

module call_stack (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       push,
    input  elev_floor_pkg::floor_t     push_floor,
    input  logic                       pop,
    input  logic                       flush,
    output elev_floor_pkg::stack_top_t top,
    output logic                       full
);

    import elev_floor_pkg::*;

    localparam int PTR_W = $clog2(`ELEV_STACK_DEPTH + 1);

    // Entry storage, ptr counts the entries held
    floor_t           mem [`ELEV_STACK_DEPTH];
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] base;
    logic             empty;
    logic             do_pop;
    logic             do_push;

    assign empty = (ptr == '0);
    assign full  = (ptr == PTR_W'(`ELEV_STACK_DEPTH));

    //////////////////////////////////////////////////
    // Pop first, then push on the freed level
    //////////////////////////////////////////////////

    assign do_pop  = pop && !empty;
    assign base    = ptr - PTR_W'(do_pop);
    assign do_push = push && (base != PTR_W'(`ELEV_STACK_DEPTH));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (flush) begin
            ptr <= '0;
        end else begin
            ptr <= base + PTR_W'(do_push);
        end
    end

    always_ff @(posedge clock) begin
        if (do_push && !flush) begin
            mem[base] <= push_floor;
        end
    end

    //////////////////////////////////////////////////
    // Top of stack view
    //////////////////////////////////////////////////

    always_comb begin
        top.valid = !empty;
        top.floor = '0;
        if (!empty) begin
            top.floor = mem[ptr - 1'b1];
        end
    end

endmodule

// File: hdl/call_latch.sv
`timescale 1ns/1ps
`include "elev_params.svh"

module call_latch (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elev_floor_pkg::floor_vec_t car_buttons,
    input  elev_floor_pkg::floor_vec_t hall_buttons,
    input  elev_car_pkg::car_status_t  status,
    input  logic                       stopped_full,
    input  logic                       travel_full,
    input  logic                       flush,
    input  logic                       arrive,
    input  elev_floor_pkg::floor_t     arrive_floor,
    output elev_floor_pkg::floor_vec_t car_lights,
    output elev_floor_pkg::floor_vec_t hall_lights,
    output logic                       stopped_push,
    output logic                       travel_push,
    output elev_floor_pkg::floor_t     push_floor
);

    import elev_floor_pkg::*;
    import elev_car_pkg::*;

    floor_vec_t own_mask;
    floor_vec_t car_cand;
    floor_vec_t hall_cand;
    floor_vec_t accept_mask;
    floor_vec_t arrive_mask;
    logic       in_travel;
    logic       target_full;
    logic       accept_car;
    logic       accept_hall;

    // Lowest pressed floor of a candidate vector
    function automatic floor_t lowest_floor(input floor_vec_t v);
        floor_t idx;
        idx = '0;
        for (int i = `ELEV_NUM_FLOORS - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = floor_t'(i);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // Press selection
    //////////////////////////////////////////////////

    assign in_travel = (status.state >= UP_F0_F1) && (status.state <= DOWN_F1_F0);
    assign target_full = in_travel ? travel_full : stopped_full;

    // The floor the car rests at cannot be requested
    assign own_mask = is_stop_state(status.state) ? (floor_vec_t'(1) << status.floor) : '0;

    assign car_cand  = car_buttons & ~car_lights & ~own_mask;
    assign hall_cand = hall_buttons & ~hall_lights & ~own_mask;

    // Car panel wins, a held hall press retries next cycle
    assign accept_car  = !flush && !target_full && (|car_cand);
    assign accept_hall = !flush && !target_full && !(|car_cand) && (|hall_cand);

    assign push_floor   = (|car_cand) ? lowest_floor(car_cand) : lowest_floor(hall_cand);
    assign stopped_push = (accept_car || accept_hall) && !in_travel;
    assign travel_push  = (accept_car || accept_hall) && in_travel;

    assign accept_mask = floor_vec_t'(1) << push_floor;
    assign arrive_mask = arrive ? (floor_vec_t'(1) << arrive_floor) : '0;

    //////////////////////////////////////////////////
    // Button lights
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_lights  <= '0;
            hall_lights <= '0;
        end else if (flush) begin
            car_lights  <= '0;
            hall_lights <= '0;
        end else begin
            car_lights  <= (car_lights & ~arrive_mask) | (accept_car ? accept_mask : '0);
            hall_lights <= (hall_lights & ~arrive_mask) | (accept_hall ? accept_mask : '0);
        end
    end

endmodule

// File: hdl/elev_car_pkg.sv
`include "elev_params.svh"

package elev_car_pkg;

    import elev_floor_pkg::*;

    //////////////////////////////////////////////////
    // Car state codes of the motion FSM
    //////////////////////////////////////////////////

    // Stop state n means the car rests at floor n
    typedef enum logic [`ELEV_STATE_W-1:0] {
        STOP_F0 = 0, STOP_F1, STOP_F2, STOP_F3,
        STOP_F4, STOP_F5, STOP_F6, STOP_F7,
        STOP_F8, STOP_F9, STOP_F10,
        // Travel upward between two floors
        UP_F0_F1, UP_F1_F2, UP_F2_F3, UP_F3_F4,
        UP_F4_F5, UP_F5_F6, UP_F6_F7, UP_F7_F8,
        UP_F8_F9, UP_F9_F10,
        // Travel downward between two floors
        DOWN_F10_F9, DOWN_F9_F8, DOWN_F8_F7, DOWN_F7_F6,
        DOWN_F6_F5, DOWN_F5_F4, DOWN_F4_F3, DOWN_F3_F2,
        DOWN_F2_F1, DOWN_F1_F0,
        EMERGENCY = `ELEV_EMERGENCY_CODE
    } car_state_t;

    //////////////////////////////////////////////////
    // Status in, dispatch out
    //////////////////////////////////////////////////

    typedef struct packed {
        car_state_t state;
        floor_t     floor;
    } car_status_t;

    // Request handed to the motion FSM
    typedef struct packed {
        floor_t target;
        logic   direction_up;
        logic   activate;
    } dispatch_t;

    function automatic logic is_stop_state(input car_state_t state);
        return state <= STOP_F10;
    endfunction

endpackage

// File: hdl/elev_floor_pkg.sv
`include "elev_params.svh"

package elev_floor_pkg;

    //////////////////////////////////////////////////
    // Floor side types
    //////////////////////////////////////////////////

    // Floor index, 0 is the ground floor
    typedef logic [`ELEV_FLOOR_W-1:0] floor_t;

    // One bit per floor, for buttons and lights
    typedef logic [`ELEV_NUM_FLOORS-1:0] floor_vec_t;

    // Top entry of a request stack
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } stack_top_t;

endpackage

// File: hdl/elev_params.svh
`ifndef ELEV_PARAMS_SVH
`define ELEV_PARAMS_SVH

// Building size and index widths
`define ELEV_NUM_FLOORS     11
`define ELEV_FLOOR_W        4

// Car state word from the motion FSM
`define ELEV_STATE_W        6
`define ELEV_EMERGENCY_CODE 31

// Entries held by each request stack
`define ELEV_STACK_DEPTH    11

`endif
